/* tb.f */
src/soc_map_pkg.sv
src/bus_pkg.sv
src/data_ram.sv
src/plic.sv
src/bus_sequencer.sv
src/bus_fabric.sv
test/tb_bus_fabric_assert.sv
test/tb_bus_fabric.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_fabric \
    -f tb.f -o sim_tb || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

/* test/tb_bus_fabric.sv */
`timescale 1ns/1ps

module tb_bus_fabric
    import bus_pkg::*;
    import soc_map_pkg::*;
();

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    bus_req;
    irq_vec_t    irq_src;
    data_t       mtime;
    data_t       read_data;
    logic        read_done;
    logic        write_done;
    data_t       mtimecmp;
    logic        meip;
    logic        seip;
    // byte image of the data ram
    logic [7:0]  ram_model [ram_words * 4];
    int          errors;
    int          tests;
    int          failed_tests;

    bus_fabric dut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .irq_src    (irq_src),
        .mtime      (mtime),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .mtimecmp   (mtimecmp),
        .meip       (meip),
        .seip       (seip)
    );

    always #5 CLOCK_50 = ~CLOCK_50;

    // little endian loads out of the byte image
    function automatic data_t load_from_model(addr_t a, ls_type_e t);
        int unsigned off;
        data_t       raw;
        off = int'(a - ram_base);
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = ram_model[off + i];
        end
        case (t)
            lb:      return {{56{raw[7]}}, raw[7:0]};
            lh:      return {{48{raw[15]}}, raw[15:0]};
            lw:      return {{32{raw[31]}}, raw[31:0]};
            lbu:     return {56'd0, raw[7:0]};
            lhu:     return {48'd0, raw[15:0]};
            lwu:     return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    // store codes 0..3 give 1, 2, 4 or 8 bytes
    task automatic store_to_model(addr_t a, ls_type_e t, data_t d);
        int unsigned off;
        int          n;
        off = int'(a - ram_base);
        n   = 1 << int'(t);
        for (int i = 0; i < n; i++) begin
            ram_model[off + i] = d[8*i +: 8];
        end
    endtask

    task automatic expect_eq(string what, data_t got, data_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s gave %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one enable pulse then count the done-low cycles until it returns
    task automatic pulse_and_wait(bit wr, addr_t a, ls_type_e t, data_t wd, output data_t rd);
        int   low;
        logic done;
        @(posedge CLOCK_50);
        bus_req.address    <= a;
        bus_req.ls_type    <= t;
        bus_req.write_data <= wd;
        if (wr) begin
            bus_req.write_enable <= 1'b1;
        end else begin
            bus_req.read_enable <= 1'b1;
        end
        @(posedge CLOCK_50);
        bus_req.write_enable <= 1'b0;
        bus_req.read_enable  <= 1'b0;
        low = 0;
        @(negedge CLOCK_50);
        done = wr ? write_done : read_done;
        while (!done && low < 20) begin
            low++;
            @(negedge CLOCK_50);
            done = wr ? write_done : read_done;
        end
        if (!done) begin
            $display("access to %h timed out, done never returned high", a);
            errors++;
        end else if (low != 1) begin
            $display("Error at %0t: done low for %0d cycles at %h", $time, low, a);
            errors++;
        end
        rd = read_data;
    endtask

    task automatic bus_read(addr_t a, ls_type_e t, output data_t d);
        pulse_and_wait(1'b0, a, t, '0, d);
    endtask

    task automatic bus_write(addr_t a, ls_type_e t, data_t wd);
        data_t unused;
        pulse_and_wait(1'b1, a, t, wd, unused);
    endtask

    task automatic report_test(string name, int errs_before);
        tests++;
        if (errors != errs_before) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic reset_defaults();
        int    e0;
        data_t d;
        e0 = errors;
        if (!read_done || !write_done || meip || seip) begin
            $display("Error at %0t: done or interrupt lines wrong after reset", $time);
            errors++;
        end
        bus_read(mtimecmp_addr, ld, d);
        expect_eq("mtimecmp after reset", d, mtimecmp_reset);
        report_test("reset", e0);
    endtask

    task automatic word_double_access();
        int    e0;
        addr_t a;
        word_t w;
        data_t v;
        data_t d;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            // keep one spare word above for the sd
            a     = ram_base + 4 * ($urandom % (ram_words - 2));
            w     = $urandom;
            // alternate the sign bit so both extensions show up
            w[31] = i[0];
            bus_write(a, lw, data_t'(w));
            store_to_model(a, lw, data_t'(w));
            bus_read(a, lw, d);
            expect_eq("lw", d, load_from_model(a, lw));
            bus_read(a, lwu, d);
            expect_eq("lwu", d, load_from_model(a, lwu));
            v = {$urandom, $urandom};
            bus_write(a, ld, v);
            store_to_model(a, ld, v);
            bus_read(a, ld, d);
            expect_eq("ld", d, load_from_model(a, ld));
            bus_read(a + 4, lw, d);
            expect_eq("lw of sd high word", d, load_from_model(a + 4, lw));
        end
        report_test("word_double", e0);
    endtask

    task automatic subword_lanes();
        int    e0;
        addr_t a;
        data_t v;
        data_t d;
        e0 = errors;
        a = ram_base + 4 * ($urandom % (ram_words - 2));
        // fill the word and its upper neighbour first
        v = {$urandom, $urandom};
        bus_write(a, ld, v);
        store_to_model(a, ld, v);
        for (int lane = 0; lane < 4; lane++) begin
            d = data_t'($urandom);
            bus_write(a + lane, lb, d);
            store_to_model(a + lane, lb, d);
            for (int k = 0; k < 4; k++) begin
                bus_read(a + k, lb, d);
                expect_eq("lb", d, load_from_model(a + k, lb));
                bus_read(a + k, lbu, d);
                expect_eq("lbu", d, load_from_model(a + k, lbu));
            end
        end
        for (int h = 0; h < 2; h++) begin
            d = data_t'($urandom);
            bus_write(a + 2 * h, lh, d);
            store_to_model(a + 2 * h, lh, d);
            for (int k = 0; k < 2; k++) begin
                bus_read(a + 2 * k, lh, d);
                expect_eq("lh", d, load_from_model(a + 2 * k, lh));
                bus_read(a + 2 * k, lhu, d);
                expect_eq("lhu", d, load_from_model(a + 2 * k, lhu));
            end
        end
        // neighbour word untouched by the byte and half stores
        bus_read(a, ld, d);
        expect_eq("ld after sub-word stores", d, load_from_model(a, ld));
        report_test("subword", e0);
    endtask

    task automatic timer_and_decode();
        int    e0;
        data_t v;
        data_t d;
        e0 = errors;
        v = {$urandom, $urandom};
        @(posedge CLOCK_50);
        mtime <= v;
        bus_read(mtime_addr, ld, d);
        expect_eq("mtime", d, v);
        v = {$urandom, $urandom};
        bus_write(mtimecmp_addr, ld, v);
        bus_read(mtimecmp_addr, ld, d);
        expect_eq("mtimecmp readback", d, v);
        expect_eq("mtimecmp port", mtimecmp, v);
        // nothing lives here
        bus_read(64'h0000_0000_2000_0000, ld, d);
        expect_eq("unmapped read", d, '0);
        report_test("timer_decode", e0);
    endtask

    task automatic plic_claim_flow();
        int    e0;
        data_t d;
        e0 = errors;
        // id 2 at prio 3 and id 4 at prio 5 on context 0
        bus_write(plic_base + 8, lw, 3);
        bus_write(plic_base + 16, lw, 5);
        bus_write(plic_enable_addr, lw, 64'b010100);
        @(posedge CLOCK_50);
        irq_src <= 6'b010100;
        @(posedge CLOCK_50);
        irq_src <= '0;
        @(negedge CLOCK_50);
        expect_eq("meip after irq", data_t'(meip), 1);
        bus_read(plic_claim_addr, lw, d);
        expect_eq("claim context 0", d, 4);
        bus_read(plic_pending_addr, lw, d);
        expect_eq("pending after claim", d, 64'b000100);
        expect_eq("meip with id 2 left", data_t'(meip), 1);
        // threshold equal to prio 3 masks id 2
        bus_write(plic_threshold_addr, lw, 3);
        expect_eq("meip after threshold", data_t'(meip), 0);
        bus_write(plic_enable_addr + plic_enable_stride, lw, 64'b000100);
        expect_eq("seip after enable", data_t'(seip), 1);
        bus_write(plic_claim_addr + plic_ctx_stride, lw, 2);
        expect_eq("seip after complete", data_t'(seip), 0);
        bus_read(plic_pending_addr, lw, d);
        expect_eq("pending after complete", d, '0);
        report_test("plic", e0);
    endtask

    initial begin
        void'($urandom(3));
        CLOCK_50     = 1'b0;
        KEY0         = 1'b0;
        bus_req      = '0;
        irq_src      = '0;
        mtime        = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        reset_defaults();
        word_double_access();
        subword_lanes();
        timer_and_decode();
        plic_claim_flow();
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, dut.u_check.fail_count);
        if (errors == 0 && dut.u_check.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* test/tb_bus_fabric_assert.sv */
`timescale 1ns/1ps

module tb_bus_fabric_assert
    import bus_pkg::*;
(
    input logic     CLOCK_50,
    input logic     KEY0,
    input bus_req_t bus_req,
    input logic     read_done,
    input logic     write_done,
    input logic     meip,
    input logic     seip
);

    // failed assertions so far
    int fail_count = 0;

    // done only drops in answer to an enable
    read_done_cause: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $fell(read_done) |-> $past(bus_req.read_enable))
        else begin
            fail_count++;
            $error("read_done fell without a read_enable");
        end

    // done back one cycle after the enable is gone
    read_done_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (!read_done && !bus_req.read_enable) |=> read_done)
        else begin
            fail_count++;
            $error("read_done stayed low with read_enable low");
        end

    write_done_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (!write_done && !bus_req.write_enable) |=> write_done)
        else begin
            fail_count++;
            $error("write_done stayed low with write_enable low");
        end

    // interrupt lines quiet in reset
    irq_in_reset: assert property (@(posedge CLOCK_50) !KEY0 |-> (!meip && !seip))
        else begin
            fail_count++;
            $error("meip or seip high during reset");
        end

endmodule

bind bus_fabric tb_bus_fabric_assert u_check (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .bus_req    (bus_req),
    .read_done  (read_done),
    .write_done (write_done),
    .meip       (meip),
    .seip       (seip)
);

/* src/bus_fabric.sv */
`timescale 1ns/1ps

module bus_fabric
    import bus_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    input  irq_vec_t irq_src,
    input  data_t    mtime,
    output data_t    read_data,
    output logic     read_done,
    output logic     write_done,
    output data_t    mtimecmp,
    output logic     meip,
    output logic     seip
);

    // per target request and read return
    target_access_t ram_access;
    target_access_t plic_access;
    data_t          ram_rdata;
    data_t          plic_rdata;

    // handshake, decode and timer compare
    bus_sequencer u_seq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus_req     (bus_req),
        .mtime       (mtime),
        .ram_rdata   (ram_rdata),
        .plic_rdata  (plic_rdata),
        .ram_access  (ram_access),
        .plic_access (plic_access),
        .read_data   (read_data),
        .read_done   (read_done),
        .write_done  (write_done),
        .mtimecmp    (mtimecmp)
    );

    data_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .access   (ram_access),
        .rdata    (ram_rdata)
    );

    plic u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .access   (plic_access),
        .irq_src  (irq_src),
        .rdata    (plic_rdata),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

/* src/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  bus_req_t       bus_req,
    input  data_t          mtime,
    input  data_t          ram_rdata,
    input  data_t          plic_rdata,
    output target_access_t ram_access,
    output target_access_t plic_access,
    output data_t          read_data,
    output logic           read_done,
    output logic           write_done,
    output data_t          mtimecmp
);

    target_e target;
    logic    rd_fire;
    logic    wr_fire;
    data_t   rd_value;

    // address decode
    always_comb begin
        target = tgt_none;
        if (bus_req.address >= ram_base && bus_req.address < ram_base + ram_bytes) begin
            target = tgt_ram;
        end else if (bus_req.address == mtime_addr) begin
            target = tgt_mtime;
        end else if (bus_req.address == mtimecmp_addr) begin
            target = tgt_mtimecmp;
        end else if (bus_req.address >= plic_base &&
                     bus_req.address < plic_base + plic_window) begin
            // whole window, plic sorts out its own offsets
            target = tgt_plic;
        end
    end

    // completion cycle: enable gone, done still low
    assign rd_fire = !bus_req.read_enable && !read_done;
    assign wr_fire = !bus_req.write_enable && !write_done;

    // fan out, strobes only toward the decoded target
    always_comb begin
        ram_access.rd          = rd_fire && (target == tgt_ram);
        ram_access.wr          = wr_fire && (target == tgt_ram);
        ram_access.address     = bus_req.address;
        ram_access.ls_type     = bus_req.ls_type;
        ram_access.write_data  = bus_req.write_data;
        plic_access.rd         = rd_fire && (target == tgt_plic);
        plic_access.wr         = wr_fire && (target == tgt_plic);
        plic_access.address    = bus_req.address;
        plic_access.ls_type    = bus_req.ls_type;
        plic_access.write_data = bus_req.write_data;
    end

    // read return select, unmapped gives zero
    always_comb begin
        case (target)
            tgt_ram:      rd_value = ram_rdata;
            tgt_mtime:    rd_value = mtime;
            tgt_mtimecmp: rd_value = mtimecmp;
            tgt_plic:     rd_value = plic_rdata;
            default:      rd_value = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done  <= 1'b1;
            write_done <= 1'b1;
            read_data  <= '0;
            mtimecmp   <= mtimecmp_reset;
        end else begin
            // enable sampled high, drop done
            if (bus_req.read_enable) begin
                read_done <= 1'b0;
            end else if (rd_fire) begin
                read_data <= rd_value;
                read_done <= 1'b1;
            end
            if (bus_req.write_enable) begin
                write_done <= 1'b0;
            end else if (wr_fire) begin
                write_done <= 1'b1;
            end
            // timer compare takes the full doubleword
            if (wr_fire && target == tgt_mtimecmp) begin
                mtimecmp <= bus_req.write_data;
            end
        end
    end

endmodule

/* src/plic.sv */
`timescale 1ns/1ps

module plic
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  target_access_t access,
    input  irq_vec_t       irq_src,
    output data_t          rdata,
    output logic           meip,
    output logic           seip
);

    prio_t                prio_reg  [1:plic_sources];
    irq_vec_t             pending;
    irq_vec_t             enable    [plic_contexts];
    prio_t                threshold [plic_contexts];
    logic [plic_id_w-1:0] claim_id  [plic_contexts];
    irq_vec_t             clr_mask;

    // claim search, strictly above threshold, lowest id wins a tie
    always_comb begin
        prio_t best;
        for (int c = 0; c < plic_contexts; c++) begin
            claim_id[c] = '0;
            best        = threshold[c];
            for (int id = 1; id <= plic_sources; id++) begin
                if (pending[id] && enable[c][id] && prio_reg[id] > best) begin
                    best        = prio_reg[id];
                    claim_id[c] = plic_id_w'(id);
                end
            end
        end
    end

    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

    // read mux and pending clears from claim or complete
    always_comb begin
        rdata    = '0;
        clr_mask = '0;
        for (int id = 1; id <= plic_sources; id++) begin
            if (access.rd && access.address == plic_base + plic_prio_stride * id) begin
                rdata = data_t'(prio_reg[id]);
            end
        end
        if (access.rd && access.address == plic_pending_addr) begin
            rdata = data_t'(pending);
        end
        for (int c = 0; c < plic_contexts; c++) begin
            if (access.rd && access.address == plic_enable_addr + plic_enable_stride * c) begin
                rdata = data_t'(enable[c]);
            end
            if (access.rd && access.address == plic_threshold_addr + plic_ctx_stride * c) begin
                rdata = data_t'(threshold[c]);
            end
            if (access.address == plic_claim_addr + plic_ctx_stride * c) begin
                // claim hands out the id and retires it
                if (access.rd) begin
                    rdata                 = data_t'(claim_id[c]);
                    clr_mask[claim_id[c]] = 1'b1;
                end
                // complete names the id to drop
                for (int id = 1; id <= plic_sources; id++) begin
                    if (access.wr && access.write_data == data_t'(id)) begin
                        clr_mask[id] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
            for (int id = 1; id <= plic_sources; id++) begin
                prio_reg[id] <= '0;
            end
            for (int c = 0; c < plic_contexts; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // clear beats set, bit 0 never pending
            pending <= (pending | {irq_src[plic_sources:1], 1'b0}) & ~clr_mask;
            if (access.wr) begin
                for (int id = 1; id <= plic_sources; id++) begin
                    if (access.address == plic_base + plic_prio_stride * id) begin
                        prio_reg[id] <= prio_t'(access.write_data);
                    end
                end
                for (int c = 0; c < plic_contexts; c++) begin
                    if (access.address == plic_enable_addr + plic_enable_stride * c) begin
                        enable[c] <= {access.write_data[plic_sources:1], 1'b0};
                    end
                    if (access.address == plic_threshold_addr + plic_ctx_stride * c) begin
                        threshold[c] <= prio_t'(access.write_data);
                    end
                end
            end
        end
    end

endmodule

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic           CLOCK_50,
    input  target_access_t access,
    output data_t          rdata
);

    word_t                mem [ram_words];
    addr_t                offset;
    logic [ram_idx_w-1:0] idx;
    logic [ram_idx_w-1:0] idx_next;
    word_t                lo_word;
    word_t                hi_word;
    word_t                byte_word;
    word_t                half_word;

    // byte offset into the ram window
    assign offset   = access.address - ram_base;
    assign idx      = offset[ram_idx_w+1:2];
    // upper word of a doubleword, wraps at the top
    assign idx_next = idx + 1'b1;

    // stores land at the completion edge
    always_ff @(posedge CLOCK_50) begin
        if (access.wr) begin
            // store codes share lb lh lw ld
            case (access.ls_type)
                lb: mem[idx][{offset[1:0], 3'b000} +: 8] <= access.write_data[7:0];
                lh: mem[idx][{offset[1], 4'b0000} +: 16] <= access.write_data[15:0];
                lw: mem[idx] <= access.write_data[31:0];
                ld: begin
                    mem[idx]      <= access.write_data[31:0];
                    mem[idx_next] <= access.write_data[63:32];
                end
                default: ;
            endcase
        end
    end

    // async read path
    assign lo_word   = mem[idx];
    assign hi_word   = mem[idx_next];
    // addressed lane moved down to bit 0
    assign byte_word = lo_word >> {offset[1:0], 3'b000};
    assign half_word = lo_word >> {offset[1], 4'b0000};

    always_comb begin
        rdata = '0;
        if (access.rd) begin
            case (access.ls_type)
                lb:  rdata = {{56{byte_word[7]}}, byte_word[7:0]};
                lh:  rdata = {{48{half_word[15]}}, half_word[15:0]};
                lw:  rdata = {{32{lo_word[31]}}, lo_word};
                // low word sits at the lower address
                ld:  rdata = {hi_word, lo_word};
                lbu: rdata = {56'd0, byte_word[7:0]};
                lhu: rdata = {48'd0, half_word[15:0]};
                lwu: rdata = {32'd0, lo_word};
                default: rdata = '0;
            endcase
        end
    end

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] word_t;
    typedef logic [2:0]  prio_t;
    // one bit per plic source, bit 0 unused
    typedef logic [5:0]  irq_vec_t;

    // load codes, stores reuse 0..3 as sb sh sw sd
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_e;

    // request from the cpu side
    typedef struct packed {
        addr_t    address;
        data_t    write_data;
        ls_type_e ls_type;
        logic     read_enable;
        logic     write_enable;
    } bus_req_t;

    // per target view, rd and wr already decoded
    typedef struct packed {
        logic     rd;
        logic     wr;
        addr_t    address;
        ls_type_e ls_type;
        data_t    write_data;
    } target_access_t;

endpackage

/* src/soc_map_pkg.sv */
package soc_map_pkg;

    // data ram, 32-bit words
    localparam logic [63:0] ram_base  = 64'h0000_0000_8000_0000;
    localparam int          ram_words = 512;
    localparam int          ram_idx_w = $clog2(ram_words);
    localparam logic [63:0] ram_bytes = 64'(ram_words * 4);

    // clint timer registers
    localparam logic [63:0] mtimecmp_addr  = 64'h0000_0000_0200_4000;
    localparam logic [63:0] mtime_addr     = 64'h0000_0000_0200_bff8;
    localparam logic [63:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    // plic window and register offsets
    localparam logic [63:0] plic_base           = 64'h0000_0000_0c00_0000;
    localparam logic [63:0] plic_window         = 64'h0000_0000_0400_0000;
    localparam logic [63:0] plic_prio_stride    = 64'd4;
    localparam logic [63:0] plic_pending_addr   = plic_base + 64'h1000;
    localparam logic [63:0] plic_enable_addr    = plic_base + 64'h2000;
    localparam logic [63:0] plic_enable_stride  = 64'h80;
    localparam logic [63:0] plic_threshold_addr = plic_base + 64'h20_0000;
    localparam logic [63:0] plic_claim_addr     = plic_base + 64'h20_0004;
    // threshold and claim step per context
    localparam logic [63:0] plic_ctx_stride     = 64'h1000;

    // source ids 1..5, id 0 means no interrupt
    localparam int plic_sources  = 5;
    // context 0 machine mode, context 1 supervisor mode
    localparam int plic_contexts = 2;
    localparam int plic_id_w     = 3;

    // decoded bus target
    typedef enum logic [2:0] {
        tgt_none,
        tgt_ram,
        tgt_mtime,
        tgt_mtimecmp,
        tgt_plic
    } target_e;

endpackage
